// ==== list.f ====
source/analog_pkg.sv
source/adc_frontend.sv
source/sample_delay.sv
source/dac_mixer.sv
source/sys_bus_decoder.sv
source/ctrl_regs.sv
source/analog_top.sv
testbench/tb_analog_top.sv

// ==== source/adc_frontend.sv ====
// --------------------
// ADC front end
// --------------------

`timescale 1ns/1ps

module adc_frontend (
  input  logic                          adc_clk,      // sample clock
  input  logic                          rst_i,        // sync reset, active high
  input  logic [analog_pkg::ADC_W-1:0]  adc_dat_a_i,  // raw code ch a
  input  logic [analog_pkg::ADC_W-1:0]  adc_dat_b_i,  // raw code ch b
  output analog_pkg::sample_t           adc_a_o,      // converted ch a
  output analog_pkg::sample_t           adc_b_o       // converted ch b
);

  // ADC delivers unsigned negative-slope codes
  // keeping the msb and flipping the rest gives two's complement
  function automatic analog_pkg::sample_t neg_to_twos(
    input logic [analog_pkg::ADC_W-1:0] raw
  );
    analog_pkg::sample_t smp;
    smp = {raw[analog_pkg::ADC_W-1], ~raw[analog_pkg::ADC_W-2:0]};  // msb kept
    return smp;
  endfunction

  // --------------------
  // input register stage
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      adc_a_o <= '0;                            // zero sample
      adc_b_o <= '0;
    end else begin
      adc_a_o <= neg_to_twos(adc_dat_a_i);      // one sample per clock
      adc_b_o <= neg_to_twos(adc_dat_b_i);
    end
  end

endmodule

// ==== source/analog_pkg.sv ====
// --------------------
// Analog path shared definitions
// --------------------

package analog_pkg;

  // --------------------
  // sample path
  localparam int ADC_W = 14;                    // ADC and DAC code width
  localparam int SUM_W = 15;                    // mixer sum before saturation

  typedef logic signed [ADC_W-1:0] sample_t;    // two's complement sample

  // --------------------
  // system bus
  localparam int BUS_AW = 32;                   // address width
  localparam int BUS_DW = 32;                   // data width

  localparam int REGION_LSB  = 20;              // region field starts here
  localparam int REGION_W    = 3;               // region field width
  localparam int NUM_REGIONS = 8;               // 2**REGION_W regions
  localparam int CTRL_REGION = 0;               // ctrl_regs lives here

  localparam int OFFSET_W = 20;                 // byte offset inside a region

  // --------------------
  // ctrl_regs map
  localparam logic [OFFSET_W-1:0] REG_LED      = 20'h00;  // led pattern
  localparam logic [OFFSET_W-1:0] REG_OFFSET_A = 20'h04;  // channel a offset
  localparam logic [OFFSET_W-1:0] REG_OFFSET_B = 20'h08;  // channel b offset
  localparam logic [OFFSET_W-1:0] REG_ID       = 20'h0C;  // identity, read only

  localparam logic [BUS_DW-1:0] ANALOG_ID = 32'h5250_0001;  // identity word

  localparam int LED_W = 8;                     // board leds

endpackage

// ==== source/analog_top.sv ====
// --------------------
// Analog path top level
// --------------------

`timescale 1ns/1ps

module analog_top #(
  parameter int DELAY_DEPTH = 4                 // delay line stages
) (
  input  logic                           adc_clk,      // ADC data clock
  input  logic                           rst_i,        // sync reset, active high
  // ADC and DAC
  input  logic [analog_pkg::ADC_W-1:0]   adc_dat_a_i,  // raw ch a
  input  logic [analog_pkg::ADC_W-1:0]   adc_dat_b_i,  // raw ch b
  output logic [analog_pkg::ADC_W-1:0]   dac_dat_a_o,  // DAC ch a
  output logic [analog_pkg::ADC_W-1:0]   dac_dat_b_o,  // DAC ch b
  output logic [analog_pkg::LED_W-1:0]   led_o,        // board leds
  // system bus
  input  logic [analog_pkg::BUS_AW-1:0]  sys_addr_i,
  input  logic [analog_pkg::BUS_DW-1:0]  sys_wdata_i,
  input  logic                           sys_wen_i,
  input  logic                           sys_ren_i,
  output logic [analog_pkg::BUS_DW-1:0]  sys_rdata_o,
  output logic                           sys_err_o,
  output logic                           sys_ack_o
);

  analog_pkg::sample_t adc_a, adc_b;            // front end out
  analog_pkg::sample_t dly_a, dly_b;            // delay line out
  analog_pkg::sample_t offset_a, offset_b;      // from ctrl_regs

  logic                          ctrl_wen, ctrl_ren;
  logic [analog_pkg::BUS_DW-1:0] ctrl_rdata;
  logic                          ctrl_err, ctrl_ack;

  // --------------------
  // sample path
  adc_frontend i_frontend (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .adc_a_o     (adc_a),
    .adc_b_o     (adc_b)
  );

  sample_delay #(.DELAY_DEPTH(DELAY_DEPTH)) i_delay (
    .adc_clk (adc_clk),
    .rst_i   (rst_i),
    .in_a_i  (adc_a),
    .in_b_i  (adc_b),
    .out_a_o (dly_a),
    .out_b_o (dly_b)
  );

  dac_mixer i_mixer (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .smp_a_i     (dly_a),
    .smp_b_i     (dly_b),
    .offset_a_i  (offset_a),
    .offset_b_i  (offset_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

  // --------------------
  // bus side
  sys_bus_decoder i_decoder (
    .adc_clk      (adc_clk),
    .rst_i        (rst_i),
    .sys_addr_i   (sys_addr_i),
    .sys_wen_i    (sys_wen_i),
    .sys_ren_i    (sys_ren_i),
    .sys_rdata_o  (sys_rdata_o),
    .sys_err_o    (sys_err_o),
    .sys_ack_o    (sys_ack_o),
    .ctrl_wen_o   (ctrl_wen),
    .ctrl_ren_o   (ctrl_ren),
    .ctrl_rdata_i (ctrl_rdata),
    .ctrl_err_i   (ctrl_err),
    .ctrl_ack_i   (ctrl_ack)
  );

  ctrl_regs i_ctrl (
    .adc_clk    (adc_clk),
    .rst_i      (rst_i),
    .reg_addr_i (sys_addr_i[analog_pkg::OFFSET_W-1:0]),  // offset inside region 0
    .wdata_i    (sys_wdata_i),
    .wen_i      (ctrl_wen),
    .ren_i      (ctrl_ren),
    .rdata_o    (ctrl_rdata),
    .err_o      (ctrl_err),
    .ack_o      (ctrl_ack),
    .led_o      (led_o),
    .offset_a_o (offset_a),
    .offset_b_o (offset_b)
  );

endmodule

// ==== source/ctrl_regs.sv ====
// --------------------
// Control registers
// --------------------

`timescale 1ns/1ps

module ctrl_regs (
  input  logic                             adc_clk,     // bus clock
  input  logic                             rst_i,       // sync reset, active high
  input  logic [analog_pkg::OFFSET_W-1:0]  reg_addr_i,  // offset inside region
  input  logic [analog_pkg::BUS_DW-1:0]    wdata_i,     // write data
  input  logic                             wen_i,       // write strobe
  input  logic                             ren_i,       // read strobe
  output logic [analog_pkg::BUS_DW-1:0]    rdata_o,     // read data
  output logic                             err_o,       // bad access
  output logic                             ack_o,       // answer pulse
  output logic [analog_pkg::LED_W-1:0]     led_o,       // led pattern
  output analog_pkg::sample_t              offset_a_o,  // mixer offset ch a
  output analog_pkg::sample_t              offset_b_o   // mixer offset ch b
);

  localparam int DW = analog_pkg::BUS_DW;
  localparam int AW = analog_pkg::ADC_W;
  localparam int LW = analog_pkg::LED_W;

  logic [LW-1:0]       led_q;
  analog_pkg::sample_t offset_a_q;
  analog_pkg::sample_t offset_b_q;
  logic [DW-1:0]       rd_val;                  // decoded read value
  logic                rd_bad;                  // unknown offset on read
  logic                wr_bad;                  // unknown or read-only on write

  // --------------------
  // address decode
  always_comb begin
    rd_val = '0;
    rd_bad = 1'b0;
    wr_bad = 1'b0;
    case (reg_addr_i)
      analog_pkg::REG_LED: begin
        rd_val = {{(DW-LW){1'b0}}, led_q};      // zero extended
      end
      analog_pkg::REG_OFFSET_A: begin
        rd_val = {{(DW-AW){offset_a_q[AW-1]}}, offset_a_q};  // sign extended
      end
      analog_pkg::REG_OFFSET_B: begin
        rd_val = {{(DW-AW){offset_b_q[AW-1]}}, offset_b_q};
      end
      analog_pkg::REG_ID: begin
        rd_val = analog_pkg::ANALOG_ID;
        wr_bad = 1'b1;                          // identity is read only
      end
      default: begin
        rd_bad = 1'b1;
        wr_bad = 1'b1;
      end
    endcase
  end

  // --------------------
  // registers and answer
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      led_q      <= '0;
      offset_a_q <= '0;
      offset_b_q <= '0;
      ack_o      <= 1'b0;
      err_o      <= 1'b0;
    end else begin
      if (wen_i && !wr_bad) begin
        case (reg_addr_i)
          analog_pkg::REG_LED:      led_q      <= wdata_i[LW-1:0];
          analog_pkg::REG_OFFSET_A: offset_a_q <= $signed(wdata_i[AW-1:0]);  // low bits only
          analog_pkg::REG_OFFSET_B: offset_b_q <= $signed(wdata_i[AW-1:0]);
          default:                  led_q      <= led_q;
        endcase
      end
      ack_o <= wen_i | ren_i;                   // always one cycle later
      err_o <= (wen_i & wr_bad) | (ren_i & rd_bad);
    end
  end

  always_ff @(posedge adc_clk) begin
    rdata_o <= ren_i ? rd_val : '0;             // writes answer with zero
  end

  assign led_o      = led_q;
  assign offset_a_o = offset_a_q;
  assign offset_b_o = offset_b_q;

  a_ack_after_strobe: assert property (@(posedge adc_clk) disable iff (rst_i)
    ack_o |-> $past(wen_i || ren_i))
    else $error("ctrl_regs: ack without a strobe in the previous cycle");

endmodule

// ==== source/dac_mixer.sv ====
// --------------------
// DAC mixer
// --------------------

`timescale 1ns/1ps

module dac_mixer (
  input  logic                          adc_clk,      // sample clock
  input  logic                          rst_i,        // sync reset, active high
  input  analog_pkg::sample_t           smp_a_i,      // delayed ch a
  input  analog_pkg::sample_t           smp_b_i,      // delayed ch b
  input  analog_pkg::sample_t           offset_a_i,   // bus offset ch a
  input  analog_pkg::sample_t           offset_b_i,   // bus offset ch b
  output logic [analog_pkg::ADC_W-1:0]  dac_dat_a_o,  // DAC code ch a
  output logic [analog_pkg::ADC_W-1:0]  dac_dat_b_o   // DAC code ch b
);

  localparam int AW = analog_pkg::ADC_W;
  localparam int SW = analog_pkg::SUM_W;

  localparam logic [AW-1:0] CODE_POS = '0;      // code of +8191
  localparam logic [AW-1:0] CODE_NEG = '1;      // code of -8192

  logic [SW-1:0] sum_a;                         // one guard bit
  logic [SW-1:0] sum_b;

  assign sum_a = {smp_a_i[AW-1], smp_a_i} + {offset_a_i[AW-1], offset_a_i};
  assign sum_b = {smp_b_i[AW-1], smp_b_i} + {offset_b_i[AW-1], offset_b_i};

  // clamp to 14 bits, then back to negative-slope DAC code
  function automatic logic [AW-1:0] to_dac(input logic [SW-1:0] sum);
    logic [AW-1:0] sat;
    if (^sum[SW-1 -: 2]) begin
      sat = {sum[SW-1], {(AW-1){~sum[SW-1]}}};  // top two bits differ, overflow
    end else begin
      sat = sum[AW-1:0];
    end
    return {sat[AW-1], ~sat[AW-2:0]};           // msb kept, rest flipped
  endfunction

  // --------------------
  // output register
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      dac_dat_a_o <= to_dac('0);                // code for sample 0
      dac_dat_b_o <= to_dac('0);
    end else begin
      dac_dat_a_o <= to_dac(sum_a);
      dac_dat_b_o <= to_dac(sum_b);
    end
  end

  // an overflowing sum must land on the matching full-scale code
  a_sat_a: assert property (@(posedge adc_clk) disable iff (rst_i)
    (^sum_a[SW-1 -: 2]) |=> dac_dat_a_o == ($past(sum_a[SW-1]) ? CODE_NEG : CODE_POS))
    else $error("dac_mixer: ch a saturation out of range");
  a_sat_b: assert property (@(posedge adc_clk) disable iff (rst_i)
    (^sum_b[SW-1 -: 2]) |=> dac_dat_b_o == ($past(sum_b[SW-1]) ? CODE_NEG : CODE_POS))
    else $error("dac_mixer: ch b saturation out of range");

endmodule

// ==== source/sample_delay.sv ====
// --------------------
// Sample delay line
// --------------------

`timescale 1ns/1ps

module sample_delay #(
  parameter int DELAY_DEPTH = 4                 // stages per channel
) (
  input  logic                 adc_clk,         // sample clock
  input  logic                 rst_i,           // sync reset, active high
  input  analog_pkg::sample_t  in_a_i,          // ch a from front end
  input  analog_pkg::sample_t  in_b_i,          // ch b from front end
  output analog_pkg::sample_t  out_a_o,         // ch a, delayed
  output analog_pkg::sample_t  out_b_o          // ch b, delayed
);

  localparam int PAIR_W = 2 * analog_pkg::ADC_W;  // both channels side by side

  logic [PAIR_W-1:0] line_q [DELAY_DEPTH];      // stage 0 is the newest

  // --------------------
  // shift line, both channels move together
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      for (int i = 0; i < DELAY_DEPTH; i++) begin
        line_q[i] <= '0;                        // flush to zero samples
      end
    end else begin
      line_q[0] <= {in_a_i, in_b_i};            // a in the upper half
      for (int i = 1; i < DELAY_DEPTH; i++) begin
        line_q[i] <= line_q[i-1];
      end
    end
  end

  assign out_a_o = line_q[DELAY_DEPTH-1][PAIR_W-1 -: analog_pkg::ADC_W];  // oldest
  assign out_b_o = line_q[DELAY_DEPTH-1][analog_pkg::ADC_W-1:0];

  // a zero-depth line would have no stage to read from
  a_depth: assert property (@(posedge adc_clk) DELAY_DEPTH >= 1)
    else $error("sample_delay: DELAY_DEPTH must be at least 1");

endmodule

// ==== source/sys_bus_decoder.sv ====
// --------------------
// System bus decoder
// --------------------

`timescale 1ns/1ps

module sys_bus_decoder (
  input  logic                           adc_clk,       // bus runs on sample clock
  input  logic                           rst_i,         // active-high sync reset
  input  logic [analog_pkg::BUS_AW-1:0]  sys_addr_i,    // byte address
  input  logic                           sys_wen_i,     // write strobe
  input  logic                           sys_ren_i,     // read strobe
  output logic [analog_pkg::BUS_DW-1:0]  sys_rdata_o,   // read data
  output logic                           sys_err_o,     // error flag
  output logic                           sys_ack_o,     // one-cycle answer
  output logic                           ctrl_wen_o,    // strobes for region 0
  output logic                           ctrl_ren_o,
  input  logic [analog_pkg::BUS_DW-1:0]  ctrl_rdata_i,  // region 0 answer
  input  logic                           ctrl_err_i,
  input  logic                           ctrl_ack_i
);

  logic [analog_pkg::REGION_W-1:0] region;      // address region field
  logic                            ctrl_sel;    // ctrl_regs region addressed
  logic                            ctrl_sel_q;  // pending request goes to ctrl_regs
  logic                            strobe;
  logic                            idle_ack_q;  // answer for empty regions

  assign region   = sys_addr_i[analog_pkg::REGION_LSB +: analog_pkg::REGION_W];
  assign ctrl_sel = (region == analog_pkg::CTRL_REGION);
  assign strobe   = sys_wen_i | sys_ren_i;

  assign ctrl_wen_o = sys_wen_i & ctrl_sel;    // gated to ctrl_regs
  assign ctrl_ren_o = sys_ren_i & ctrl_sel;

  // --------------------
  // request tracking
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      ctrl_sel_q <= 1'b0;
      idle_ack_q <= 1'b0;
    end else begin
      if (strobe) begin
        ctrl_sel_q <= ctrl_sel;                 // remember who answers
      end
      idle_ack_q <= strobe & ~ctrl_sel;         // regions 1..7
    end
  end

  // --------------------
  // answer mux
  always_comb begin
    if (ctrl_sel_q) begin
      sys_rdata_o = ctrl_rdata_i;
      sys_err_o   = ctrl_err_i;
      sys_ack_o   = ctrl_ack_i;
    end else begin
      sys_rdata_o = '0;                         // unused regions read zero
      sys_err_o   = 1'b0;
      sys_ack_o   = idle_ack_q;
    end
  end

  a_one_strobe: assert property (@(posedge adc_clk) disable iff (rst_i)
    !(sys_wen_i && sys_ren_i))
    else $error("sys_bus_decoder: write and read strobe together");

endmodule

// ==== testbench/tb_analog_top.sv ====
// --------------------
// Analog top testbench
// --------------------

`timescale 1ns/1ps

module tb_analog_top;

  localparam int DELAY_DEPTH = 4;
  localparam int LAT         = DELAY_DEPTH + 2;       // raw in to DAC out, in cycles
  localparam int MAX_CYCLES  = 2000;                  // tests need about 400
  localparam logic [13:0] ZERO_CODE = 14'h1FFF;       // raw and DAC code of sample 0

  logic        adc_clk = 1'b0;
  logic        rst_i;
  logic [13:0] adc_dat_a_i, adc_dat_b_i;
  logic [13:0] dac_dat_a_o, dac_dat_b_o;
  logic [7:0]  led_o;
  logic [31:0] sys_addr_i, sys_wdata_i, sys_rdata_o;
  logic        sys_wen_i, sys_ren_i, sys_err_o, sys_ack_o;

  logic [7:0]  m_led;                                 // register model
  logic [13:0] m_off_a, m_off_b;
  logic [13:0] hist_a[$], hist_b[$];                  // raw codes in flight
  logic [13:0] next_a, next_b;                        // raw codes for the next tick
  integer      seed;
  int          errors, tests, bad_tests;
  int          cycles = 0;

  analog_top #(.DELAY_DEPTH(DELAY_DEPTH)) i_dut (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .led_o       (led_o),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_err_o   (sys_err_o),
    .sys_ack_o   (sys_ack_o)
  );

  always #50 adc_clk = ~adc_clk;                      // 100 ns period

  always @(posedge adc_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run went past %0d cycles", MAX_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  // --------------------
  // reference rules
  function automatic logic [13:0] predict_code(input logic [13:0] raw, input logic [13:0] off);
    logic signed [13:0] smp_s, off_s;
    int                 sum;
    smp_s = raw ^ 14'h1FFF;                           // negative slope to two's complement
    off_s = off;
    sum   = int'(smp_s) + int'(off_s);
    if (sum > 8191) sum = 8191;
    else if (sum < -8192) sum = -8192;
    return 14'(sum) ^ 14'h1FFF;                       // back to DAC code
  endfunction

  function automatic logic [13:0] to_raw(input int smp);
    return 14'(smp) ^ 14'h1FFF;
  endfunction

  function automatic logic [31:0] reg_addr(input int region, input logic [19:0] off);
    return (32'(region) << analog_pkg::REGION_LSB) | 32'(off);
  endfunction

  function automatic logic access_err(input logic wr, input logic [31:0] addr);
    logic [19:0] off;
    off = addr[19:0];
    if (addr[22:20] != 3'd0) return 1'b0;             // empty regions never flag
    if (off == analog_pkg::REG_LED || off == analog_pkg::REG_OFFSET_A) return 1'b0;
    if (off == analog_pkg::REG_OFFSET_B) return 1'b0;
    if (off == analog_pkg::REG_ID) return wr;         // identity is read only
    return 1'b1;
  endfunction

  function automatic logic [31:0] model_rdata(input logic [31:0] addr);
    if (addr[22:20] != 3'd0) return 32'h0;
    case (addr[19:0])
      analog_pkg::REG_LED:      return {24'h0, m_led};
      analog_pkg::REG_OFFSET_A: return {{18{m_off_a[13]}}, m_off_a};
      analog_pkg::REG_OFFSET_B: return {{18{m_off_b[13]}}, m_off_b};
      analog_pkg::REG_ID:       return 32'h5250_0001;
      default:                  return 32'h0;
    endcase
  endfunction

  // --------------------
  // checking helpers
  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  // compare DAC outputs on a falling edge and drive the next raw pair
  task automatic step();
    logic [13:0] raw_a, raw_b;
    @(negedge adc_clk);
    raw_a = hist_a.pop_front();
    raw_b = hist_b.pop_front();
    expect_eq("dac_dat_a_o", dac_dat_a_o, predict_code(raw_a, m_off_a));
    expect_eq("dac_dat_b_o", dac_dat_b_o, predict_code(raw_b, m_off_b));
    adc_dat_a_i = next_a;
    adc_dat_b_i = next_b;
    hist_a.push_back(next_a);
    hist_b.push_back(next_b);
  endtask

  task automatic bus_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata);
    logic        exp_err;
    logic [31:0] exp_data;
    exp_err     = access_err(wr, addr);
    exp_data    = wr ? 32'h0 : model_rdata(addr); // writes answer with zero
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_wen_i   = wr;
    sys_ren_i   = !wr;
    step();
    sys_wen_i = 1'b0;                                 // one-cycle strobe
    sys_ren_i = 1'b0;
    if (sys_ack_o !== 1'b1) begin
      $display("no acknowledge one cycle after the strobe to address 0x%h", addr);
      errors++;
    end
    expect_eq("sys_err_o", sys_err_o, exp_err);
    expect_eq("sys_rdata_o", sys_rdata_o, exp_data);
    if (wr && !exp_err && addr[22:20] == 3'd0) begin
      case (addr[19:0])
        analog_pkg::REG_LED:      m_led   = wdata[7:0];
        analog_pkg::REG_OFFSET_A: m_off_a = wdata[13:0];   // low bits only
        analog_pkg::REG_OFFSET_B: m_off_b = wdata[13:0];
        default: ;
      endcase
    end
    step();
    if (sys_ack_o !== 1'b0) begin
      $display("acknowledge to address 0x%h stayed high for a second cycle", addr);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int start);
    tests++;
    if (errors > start) begin
      bad_tests++;
      $display("test %s: %0d errors", name, errors - start);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // --------------------
  // directed tests
  task automatic test_reset_state();
    int start;
    start = errors;
    expect_eq("led_o", led_o, 32'h0);
    expect_eq("sys_ack_o", sys_ack_o, 32'h0);
    expect_eq("dac_dat_a_o", dac_dat_a_o, ZERO_CODE);
    expect_eq("dac_dat_b_o", dac_dat_b_o, ZERO_CODE);
    next_a = 14'h0ABC;
    next_b = 14'h3456;
    repeat (LAT + 1) step();                          // zero codes come out before the samples
    report_test("reset_state", start);
  endtask

  task automatic test_passthrough();
    int start;
    start = errors;
    repeat (24) begin
      next_a = $random(seed);
      next_b = $random(seed);
      step();
    end
    repeat (LAT) step();                              // hold the last pair until it emerges
    expect_eq("dac_dat_a_o", dac_dat_a_o, next_a);
    expect_eq("dac_dat_b_o", dac_dat_b_o, next_b);
    report_test("passthrough", start);
  endtask

  task automatic test_saturation();
    int start;
    start = errors;
    bus_xfer(1'b1, reg_addr(0, analog_pkg::REG_OFFSET_A), 32'(8000));
    bus_xfer(1'b1, reg_addr(0, analog_pkg::REG_OFFSET_B), 32'(-8000));
    next_a = to_raw(1000);
    next_b = to_raw(-1000);
    repeat (LAT + 1) step();                          // new pair emerges on the last step
    expect_eq("dac_dat_a_o", dac_dat_a_o, 14'h0000);  // clamped to +8191
    expect_eq("dac_dat_b_o", dac_dat_b_o, 14'h3FFF);  // clamped to -8192
    report_test("saturation", start);
  endtask

  task automatic test_registers();
    int start;
    start = errors;
    bus_xfer(1'b1, reg_addr(0, analog_pkg::REG_LED), 32'h0000_00A5);
    bus_xfer(1'b0, reg_addr(0, analog_pkg::REG_LED), 32'h0);
    expect_eq("led_o", led_o, 32'hA5);
    bus_xfer(1'b1, reg_addr(0, analog_pkg::REG_OFFSET_A), 32'h0000_1234);
    bus_xfer(1'b0, reg_addr(0, analog_pkg::REG_OFFSET_A), 32'h0);
    bus_xfer(1'b1, reg_addr(0, analog_pkg::REG_OFFSET_B), 32'hFFFF_E000);
    bus_xfer(1'b0, reg_addr(0, analog_pkg::REG_OFFSET_B), 32'h0);
    bus_xfer(1'b0, reg_addr(0, analog_pkg::REG_ID), 32'h0);
    bus_xfer(1'b1, reg_addr(0, analog_pkg::REG_ID), 32'hDEAD_BEEF);  // err expected
    bus_xfer(1'b1, reg_addr(0, 20'h10), 32'h0000_005A);
    bus_xfer(1'b0, reg_addr(0, 20'h10), 32'h0);
    bus_xfer(1'b0, reg_addr(0, analog_pkg::REG_ID), 32'h0);
    bus_xfer(1'b0, reg_addr(0, analog_pkg::REG_LED), 32'h0);         // still 0xA5
    bus_xfer(1'b0, reg_addr(0, analog_pkg::REG_OFFSET_A), 32'h0);
    bus_xfer(1'b0, reg_addr(0, analog_pkg::REG_OFFSET_B), 32'h0);
    report_test("registers", start);
  endtask

  task automatic test_empty_regions();
    int start;
    start = errors;
    for (int r = 1; r < analog_pkg::NUM_REGIONS; r++) begin
      bus_xfer(1'b0, reg_addr(r, analog_pkg::REG_OFFSET_A), 32'h0);
      bus_xfer(1'b1, reg_addr(r, analog_pkg::REG_LED), 32'h0000_00FF);
    end
    bus_xfer(1'b0, reg_addr(0, analog_pkg::REG_LED), 32'h0);         // ctrl_regs untouched
    expect_eq("led_o", led_o, {24'h0, m_led});
    report_test("empty_regions", start);
  endtask

  task automatic test_random_stream();
    int start;
    start = errors;
    for (int i = 0; i < 200; i++) begin
      if (i % 50 == 0) begin
        bus_xfer(1'b1, reg_addr(0, analog_pkg::REG_OFFSET_A), $random(seed));
        bus_xfer(1'b1, reg_addr(0, analog_pkg::REG_OFFSET_B), $random(seed));
      end
      next_a = $random(seed);
      next_b = $random(seed);
      step();
    end
    repeat (LAT) step();                              // drain the pipeline
    report_test("random_stream", start);
  endtask

  // --------------------
  // main sequence
  initial begin
    seed        = 21308;
    errors      = 0;
    tests       = 0;
    bad_tests   = 0;
    rst_i       = 1'b1;
    adc_dat_a_i = ZERO_CODE;
    adc_dat_b_i = ZERO_CODE;
    sys_addr_i  = 32'h0;
    sys_wdata_i = 32'h0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    next_a      = ZERO_CODE;
    next_b      = ZERO_CODE;
    m_led       = 8'h0;
    m_off_a     = 14'h0;
    m_off_b     = 14'h0;
    repeat (2) @(negedge adc_clk);                    // two reset cycles
    rst_i = 1'b0;
    repeat (LAT) begin
      hist_a.push_back(ZERO_CODE);                    // pipeline holds zero samples
      hist_b.push_back(ZERO_CODE);
    end
    test_reset_state();
    test_passthrough();
    test_saturation();
    test_registers();
    test_empty_regions();
    test_random_stream();
    $display("tests run %0d, tests with errors %0d, failed checks %0d",
             tests, bad_tests, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
